/* verilog/md_cfg.svh */
/*
 * multiply/divide unit configuration
 * operand, half-word and accumulator widths and the divider step count
 */
`ifndef MD_CFG_SVH
`define MD_CFG_SVH

// operand and result width
`define MD_XLEN 32

// MAC factor width, one half of an operand
`define MD_HALF 16

// accumulator keeps two guard bits over the operand width
`define MD_ACC_W 34

// divider step counter
`define MD_CNT_W 5

// compare steps before the last step
`define MD_DIV_STEPS 31

`endif

/* verilog/md_pkg.sv */
/*
 * multiply/divide unit package
 * data widths and the operation and state encodings
 */
`default_nettype none
`include "md_cfg.svh"

package md_pkg;

  // data types
  typedef logic [`MD_XLEN-1:0]  operand_t;
  typedef logic [`MD_HALF-1:0]  half_t;
  typedef logic [`MD_ACC_W-1:0] acc_t;
  // bit 0 marks a as signed, bit 1 marks b as signed
  typedef logic [1:0]           sign_mode_t;
  typedef logic [`MD_CNT_W-1:0] count_t;

  // MULH covers MULH, MULHSU and MULHU through the sign mode
  typedef enum logic [1:0] {MD_OP_MUL, MD_OP_MULH, MD_OP_DIV, MD_OP_REM} md_op_e;

  // multiplier partial-product steps
  typedef enum logic [1:0] {ALBL, ALBH, AHBL, AHBH} mult_state_e;

  // long divider
  typedef enum logic [2:0] {
    DIV_IDLE, DIV_ABS_A, DIV_ABS_B, DIV_COMP, DIV_LAST, DIV_CHANGE_SIGN, DIV_FINISH
  } div_state_e;

  // request/acknowledge controller
  typedef enum logic [1:0] {CTL_IDLE, CTL_BUSY, CTL_ACK} ctl_state_e;

endpackage

`default_nettype wire

/* verilog/md_engine_if.sv */
/*
 * control-to-engine link of the multiply/divide unit
 * one start pulse in, one done pulse with the result out
 */
`timescale 1ns/1ps
`default_nettype none

interface md_engine_if;

  // one-cycle strobe, only while the engine is idle
  logic               start;
  // operation and operands, stable from start until done
  md_pkg::md_op_e     op;
  md_pkg::sign_mode_t sign_mode;
  md_pkg::operand_t   op_a;
  md_pkg::operand_t   op_b;
  // one-cycle strobe, result valid in the same cycle
  logic               done;
  md_pkg::operand_t   result;

  // controller side
  modport ctrl (
    output start, op, sign_mode, op_a, op_b,
    input  done, result
  );

  // arithmetic engine side
  modport engine (
    input  start, op, sign_mode, op_a, op_b,
    output done, result
  );

endinterface

`default_nettype wire

/* verilog/md_mult_mac.sv */
/*
 * multi-cycle multiplier engine
 * one 17x17 signed MAC builds MUL in three and MULH/MULHSU/MULHU in four steps
 */
`timescale 1ns/1ps
`default_nettype none
`include "md_cfg.svh"

module md_mult_mac (
  input  logic      clk_i,
  input  logic      rst_ni,
  md_engine_if.engine bus
);

  localparam int unsigned XW = `MD_XLEN;
  localparam int unsigned HW = `MD_HALF;
  localparam int unsigned AW = `MD_ACC_W;

  md_pkg::mult_state_e state_q, state_d;
  md_pkg::acc_t        acc_q, acc_d;
  md_pkg::acc_t        accum;
  md_pkg::acc_t        mac_res;
  md_pkg::half_t       mult_op_a, mult_op_b;
  logic                sign_a, sign_b;
  logic                signed_mult;
  logic                is_mul;

  // any signed operand makes the partial sums signed
  assign signed_mult = (bus.sign_mode != 2'b00);
  assign is_mul      = (bus.op == md_pkg::MD_OP_MUL);

  // single MAC, the 35th sum bit always equals bit 33 and is dropped
  assign mac_res = $signed({sign_a, mult_op_a}) * $signed({sign_b, mult_op_b})
                 + $signed(accum);

  always_comb begin
    mult_op_a  = bus.op_a[HW-1:0];
    mult_op_b  = bus.op_b[HW-1:0];
    sign_a     = 1'b0;
    sign_b     = 1'b0;
    accum      = '0;
    acc_d      = acc_q;
    state_d    = state_q;
    bus.done   = 1'b0;
    bus.result = mac_res[XW-1:0];

    unique case (state_q)
      md_pkg::ALBL: begin
        // al*bl, both halves unsigned
        // doubles as the idle state
        if (bus.start) begin
          acc_d   = mac_res;
          state_d = md_pkg::ALBH;
        end
      end

      md_pkg::ALBH: begin
        // al*bh<<16
        mult_op_b = bus.op_b[XW-1:HW];
        sign_b    = bus.sign_mode[1] & bus.op_b[XW-1];
        // upper half of al*bl, never negative
        accum     = {{(AW-HW){1'b0}}, acc_q[XW-1:HW]};
        if (is_mul) begin
          // keep product bits 15:0 below the new middle part
          acc_d = {{(AW-XW){1'b0}}, mac_res[HW-1:0], acc_q[HW-1:0]};
        end else begin
          acc_d = mac_res;
        end
        state_d = md_pkg::AHBL;
      end

      md_pkg::AHBL: begin
        // ah*bl<<16
        mult_op_a = bus.op_a[XW-1:HW];
        sign_a    = bus.sign_mode[0] & bus.op_a[XW-1];
        if (is_mul) begin
          // only the low word is needed, the carry into bit 32 is lost
          accum      = {{(AW-HW){1'b0}}, acc_q[XW-1:HW]};
          bus.result = {mac_res[HW-1:0], acc_q[HW-1:0]};
          bus.done   = 1'b1;
          state_d    = md_pkg::ALBL;
        end else begin
          accum   = acc_q;
          acc_d   = mac_res;
          state_d = md_pkg::AHBH;
        end
      end

      md_pkg::AHBH: begin
        // ah*bh<<32, MULH family only
        mult_op_a  = bus.op_a[XW-1:HW];
        mult_op_b  = bus.op_b[XW-1:HW];
        sign_a     = bus.sign_mode[0] & bus.op_a[XW-1];
        sign_b     = bus.sign_mode[1] & bus.op_b[XW-1];
        // middle sum moved down 16 bits
        // sign-extended unless both operands are unsigned
        accum      = {{HW{signed_mult & acc_q[AW-1]}}, acc_q[AW-1:HW]};
        bus.result = mac_res[XW-1:0];
        bus.done   = 1'b1;
        state_d    = md_pkg::ALBL;
      end

      default: begin
        state_d = md_pkg::ALBL;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= md_pkg::ALBL;
    end else begin
      state_q <= state_d;
    end
  end

  // partial sum register
  always_ff @(posedge clk_i) begin
    acc_q <= acc_d;
  end

endmodule

`default_nettype wire

/* verilog/md_div_long.sv */
/*
 * long divider engine for DIV/DIVU/REM/REMU
 * absolute values, restoring compare/subtract per bit, then sign fix
 */
`timescale 1ns/1ps
`default_nettype none
`include "md_cfg.svh"

module md_div_long (
  input  logic      clk_i,
  input  logic      rst_ni,
  md_engine_if.engine bus
);

  localparam int unsigned XW = `MD_XLEN;

  md_pkg::div_state_e state_q, state_d;
  md_pkg::operand_t   rem_q, rem_d;
  md_pkg::operand_t   quot_q, quot_d;
  md_pkg::operand_t   numer_q, numer_d;
  md_pkg::operand_t   denom_q, denom_d;
  md_pkg::count_t     cnt_q, cnt_d;
  logic               div_by_zero_q, div_by_zero_d;

  logic [XW:0]        add_a, add_b, add_sum;
  md_pkg::operand_t   add_res;
  md_pkg::operand_t   one_shift;
  md_pkg::operand_t   next_rem;
  md_pkg::operand_t   next_quot;
  logic               is_greater_equal;
  logic               is_div;
  logic               b_is_zero;
  logic               div_sign_a, div_sign_b;
  logic               div_change_sign, rem_change_sign;

  assign is_div    = (bus.op == md_pkg::MD_OP_DIV);
  assign b_is_zero = (bus.op_b == '0);

  // shared adder, {x,1} + {~y,1} puts x - y in the upper 32 bits
  assign add_sum = add_a + add_b;
  assign add_res = add_sum[XW:1];

  // unsigned compare of remainder and divisor magnitudes
  always_comb begin
    if ((rem_q[XW-1] ^ denom_q[XW-1]) == 1'b0) begin
      is_greater_equal = ~add_res[XW-1];
    end else begin
      is_greater_equal = rem_q[XW-1];
    end
  end

  // quotient bit for the current step
  assign one_shift = {{(XW-1){1'b0}}, 1'b1} << cnt_q;
  assign next_rem  = is_greater_equal ? add_res : rem_q;
  assign next_quot = is_greater_equal ? (quot_q | one_shift) : quot_q;

  assign div_sign_a      = bus.op_a[XW-1] & bus.sign_mode[0];
  assign div_sign_b      = bus.op_b[XW-1] & bus.sign_mode[1];
  // a zero divisor never takes the sign fix
  assign div_change_sign = (div_sign_a ^ div_sign_b) & ~div_by_zero_q;
  // remainder follows the dividend sign
  assign rem_change_sign = div_sign_a;

  // result register holds the final value in FINISH
  assign bus.result = rem_q;

  always_comb begin
    state_d       = state_q;
    rem_d         = rem_q;
    quot_d        = quot_q;
    numer_d       = numer_q;
    denom_d       = denom_q;
    cnt_d         = cnt_q - 1'b1;
    div_by_zero_d = div_by_zero_q;
    // default adder job is 0 - b
    add_a         = {{XW{1'b0}}, 1'b1};
    add_b         = {~bus.op_b, 1'b1};
    bus.done      = 1'b0;

    unique case (state_q)
      md_pkg::DIV_IDLE: begin
        if (bus.start) begin
          // preset the divide-by-zero answers
          // all-ones quotient, remainder equal to the dividend
          rem_d         = is_div ? '1 : bus.op_a;
          div_by_zero_d = b_is_zero;
          state_d       = b_is_zero ? md_pkg::DIV_FINISH : md_pkg::DIV_ABS_A;
        end
        cnt_d = md_pkg::count_t'(`MD_DIV_STEPS);
      end

      md_pkg::DIV_ABS_A: begin
        // |a| = 0 - a when signed and negative
        add_b   = {~bus.op_a, 1'b1};
        quot_d  = '0;
        numer_d = div_sign_a ? add_res : bus.op_a;
        cnt_d   = md_pkg::count_t'(`MD_DIV_STEPS);
        state_d = md_pkg::DIV_ABS_B;
      end

      md_pkg::DIV_ABS_B: begin
        // first partial remainder is the top numerator bit
        rem_d   = {{(XW-1){1'b0}}, numer_q[XW-1]};
        denom_d = div_sign_b ? add_res : bus.op_b;
        cnt_d   = md_pkg::count_t'(`MD_DIV_STEPS);
        state_d = md_pkg::DIV_COMP;
      end

      md_pkg::DIV_COMP: begin
        // remainder - divisor, then shift in the next numerator bit
        add_a   = {rem_q, 1'b1};
        add_b   = {~denom_q, 1'b1};
        rem_d   = {next_rem[XW-2:0], numer_q[cnt_d]};
        quot_d  = next_quot;
        state_d = (cnt_q == md_pkg::count_t'(1)) ? md_pkg::DIV_LAST : md_pkg::DIV_COMP;
      end

      md_pkg::DIV_LAST: begin
        // bit 0, keep only the value the operation asks for
        add_a   = {rem_q, 1'b1};
        add_b   = {~denom_q, 1'b1};
        rem_d   = is_div ? next_quot : next_rem;
        state_d = md_pkg::DIV_CHANGE_SIGN;
      end

      md_pkg::DIV_CHANGE_SIGN: begin
        // 0 - magnitude when the result must be negative
        add_b = {~rem_q, 1'b1};
        if (is_div ? div_change_sign : rem_change_sign) begin
          rem_d = add_res;
        end
        state_d = md_pkg::DIV_FINISH;
      end

      md_pkg::DIV_FINISH: begin
        bus.done = 1'b1;
        state_d  = md_pkg::DIV_IDLE;
      end

      default: begin
        state_d = md_pkg::DIV_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= md_pkg::DIV_IDLE;
      cnt_q         <= '0;
      div_by_zero_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      cnt_q         <= cnt_d;
      div_by_zero_q <= div_by_zero_d;
    end
  end

  // datapath registers
  always_ff @(posedge clk_i) begin
    rem_q   <= rem_d;
    quot_q  <= quot_d;
    numer_q <= numer_d;
    denom_q <= denom_d;
  end

endmodule

`default_nettype wire

/* verilog/md_unit.sv */
/*
 * multiply/divide unit top level
 * four-phase req/ack, dispatch to the MAC multiplier or the long divider
 */
`timescale 1ns/1ps
`default_nettype none

module md_unit (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_i,
  input  md_pkg::md_op_e     operator_i,
  input  md_pkg::sign_mode_t sign_mode_i,
  input  md_pkg::operand_t   op_a_i,
  input  md_pkg::operand_t   op_b_i,
  output logic               ack_o,
  output md_pkg::operand_t   result_o
);

  md_pkg::ctl_state_e state_q, state_d;
  md_pkg::md_op_e     op_q;
  md_pkg::sign_mode_t mode_q;
  md_pkg::operand_t   a_q, b_q;
  md_pkg::operand_t   result_q;
  md_pkg::operand_t   eng_result;
  logic               start_mult_q, start_div_q;
  logic               resp_q;
  logic               accept;
  logic               is_div_req, is_div_q;
  logic               eng_done;

  md_engine_if mult_bus ();
  md_engine_if div_bus ();

  md_mult_mac u_mult (
    .clk_i,
    .rst_ni,
    .bus (mult_bus)
  );

  md_div_long u_div (
    .clk_i,
    .rst_ni,
    .bus (div_bus)
  );

  // new request only from IDLE, so ack_o is already low
  assign accept     = (state_q == md_pkg::CTL_IDLE) & req_i;
  assign is_div_req = (operator_i == md_pkg::MD_OP_DIV) | (operator_i == md_pkg::MD_OP_REM);
  assign is_div_q   = (op_q == md_pkg::MD_OP_DIV) | (op_q == md_pkg::MD_OP_REM);

  // both engines see the registered request
  assign mult_bus.start     = start_mult_q;
  assign mult_bus.op        = op_q;
  assign mult_bus.sign_mode = mode_q;
  assign mult_bus.op_a      = a_q;
  assign mult_bus.op_b      = b_q;
  assign div_bus.start      = start_div_q;
  assign div_bus.op         = op_q;
  assign div_bus.sign_mode  = mode_q;
  assign div_bus.op_a       = a_q;
  assign div_bus.op_b       = b_q;

  // only the engine that was started can finish
  assign eng_done   = is_div_q ? div_bus.done : mult_bus.done;
  assign eng_result = is_div_q ? div_bus.result : mult_bus.result;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      md_pkg::CTL_IDLE: if (req_i) state_d = md_pkg::CTL_BUSY;
      // wait one cycle after done so result_o settles before ack
      md_pkg::CTL_BUSY: if (resp_q) state_d = md_pkg::CTL_ACK;
      // hold ack until the requester drops req
      md_pkg::CTL_ACK:  if (!req_i) state_d = md_pkg::CTL_IDLE;
      default:          state_d = md_pkg::CTL_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= md_pkg::CTL_IDLE;
      start_mult_q <= 1'b0;
      start_div_q  <= 1'b0;
      resp_q       <= 1'b0;
    end else begin
      state_q      <= state_d;
      // one-cycle start strobes
      start_mult_q <= accept & ~is_div_req;
      start_div_q  <= accept & is_div_req;
      resp_q       <= eng_done;
    end
  end

  // request and result registers
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q   <= operator_i;
      mode_q <= sign_mode_i;
      a_q    <= op_a_i;
      b_q    <= op_b_i;
    end
    if (eng_done) begin
      result_q <= eng_result;
    end
  end

  assign ack_o    = (state_q == md_pkg::CTL_ACK);
  assign result_o = result_q;

endmodule

`default_nettype wire

/* verif/md_unit_sva.sv */
/*
 * handshake assertions for the multiply/divide unit
 * bound to the top level, watches req/ack and the result hold
 */
`timescale 1ns/1ps
`default_nettype none

module md_unit_sva (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             req_i,
  input logic             ack_i,
  input md_pkg::operand_t result_i
);

  // ack only answers a pending request
  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!req_i && !ack_i) |=> !ack_i)
    else $error("ack_o rose while req_i was low");

  // ack held for as long as req stays high
  ack_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ack_i && req_i) |=> ack_i)
    else $error("ack_o dropped while req_i was high");

  // result must not move under ack
  result_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_i |=> (!ack_i || $stable(result_i)))
    else $error("result_o changed while ack_o was high");

  // leaving reset with no ack
  ack_low_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !ack_i)
    else $error("ack_o high after reset");

endmodule

bind md_unit md_unit_sva u_sva (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .req_i    (req_i),
  .ack_i    (ack_o),
  .result_i (result_o)
);

`default_nettype wire

/* verif/md_unit_tb.sv */
/*
 * directed testbench for the multiply/divide unit
 * four-phase requests, result, latency and ack timing checks
 */
`timescale 1ns/1ps
`default_nettype none
`include "md_cfg.svh"

module md_unit_tb;

  localparam int XW       = `MD_XLEN;
  localparam int N_RAND   = 50;
  localparam int LAT_MUL  = 4;
  localparam int LAT_MULH = 5;
  localparam int LAT_DIV  = `MD_DIV_STEPS + 7;
  localparam int LAT_DIV0 = 3;
  // mul and three mulh modes, signed/unsigned div and rem, corners, handshake
  localparam int NUM_OPS  = 4 * (16 + N_RAND) + 4 * N_RAND + 10 + 2 + 8;
  localparam int MAX_CYC  = NUM_OPS * (LAT_DIV + 4) + 200;

  logic               clk_i = 1'b0;
  logic               rst_ni;
  logic               req_i;
  md_pkg::md_op_e     operator_i;
  md_pkg::sign_mode_t sign_mode_i;
  md_pkg::operand_t   op_a_i;
  md_pkg::operand_t   op_b_i;
  logic               ack_o;
  md_pkg::operand_t   result_o;
  int                 cycles = 0;
  md_pkg::operand_t   corner [4];

  md_unit DUT (
    .clk_i, .rst_ni, .req_i, .operator_i, .sign_mode_i,
    .op_a_i, .op_b_i, .ack_o, .result_o
  );

  always #5 clk_i = ~clk_i;

  // run limit
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYC) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYC);
      $display("TB FAILED");
      $fatal(1, "simulation timeout");
    end
  end

  task automatic check_result(input string what, input md_pkg::operand_t got,
                              input md_pkg::operand_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s result %08h expected %08h", $time, what, got, exp);
      $display("TB FAILED");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic expect_ack(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s ack_o %b expected %b", $time, what, got, exp);
      $display("TB FAILED");
      $fatal(1, "ack mismatch");
    end
  endtask

  task automatic compare_latency(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("FAILED at %0t: %s ack after %0d edges expected %0d", $time, what, got, exp);
      $display("TB FAILED");
      $fatal(1, "latency mismatch");
    end
  endtask

  // expected values straight from the operation definitions
  function automatic md_pkg::operand_t mul_ref(input md_pkg::operand_t a,
                                               input md_pkg::operand_t b);
    logic [2*XW-1:0] p;
    p = {{XW{1'b0}}, a} * {{XW{1'b0}}, b};
    return p[XW-1:0];
  endfunction

  function automatic md_pkg::operand_t mulh_ref(input md_pkg::sign_mode_t mode,
                                                input md_pkg::operand_t a,
                                                input md_pkg::operand_t b);
    logic [2*XW-1:0] p;
    p = {{XW{mode[0] & a[XW-1]}}, a} * {{XW{mode[1] & b[XW-1]}}, b};
    return p[2*XW-1:XW];
  endfunction

  // truncating division with the remainder taken from a = q*b + r
  function automatic void divrem_ref(input logic sgn, input md_pkg::operand_t a,
                                     input md_pkg::operand_t b,
                                     output md_pkg::operand_t q,
                                     output md_pkg::operand_t r);
    logic             neg_a, neg_b;
    md_pkg::operand_t ma, mb;
    neg_a = sgn & a[XW-1];
    neg_b = sgn & b[XW-1];
    ma    = neg_a ? -a : a;
    mb    = neg_b ? -b : b;
    if (b == '0) begin
      q = '1;
      r = a;
    end else begin
      q = ma / mb;
      if (neg_a ^ neg_b) q = -q;
      r = a - q * b;
    end
  endfunction

  function automatic int div_latency(input md_pkg::operand_t b);
    return (b == '0) ? LAT_DIV0 : LAT_DIV;
  endfunction

  // one full four-phase transfer with an optional hold of req after ack
  task automatic do_op(input md_pkg::md_op_e op, input md_pkg::sign_mode_t mode,
                       input md_pkg::operand_t a, input md_pkg::operand_t b,
                       input md_pkg::operand_t exp, input int lat, input int hold,
                       output md_pkg::operand_t res);
    string tag;
    int    n;
    tag = $sformatf("%s mode=%b a=%08h b=%08h", op.name(), mode, a, b);
    @(posedge clk_i);
    req_i       <= 1'b1;
    operator_i  <= op;
    sign_mode_i <= mode;
    op_a_i      <= a;
    op_b_i      <= b;
    // edge 0 samples the request here
    @(posedge clk_i);
    n = 0;
    @(negedge clk_i);
    while (!ack_o) begin
      @(negedge clk_i);
      n++;
    end
    compare_latency(tag, n, lat);
    check_result(tag, result_o, exp);
    res = result_o;
    repeat (hold) begin
      @(negedge clk_i);
      expect_ack(tag, ack_o, 1'b1);
      check_result(tag, result_o, res);
    end
    @(posedge clk_i);
    req_i <= 1'b0;
    // ack falls on the first edge that samples req low
    @(negedge clk_i);
    expect_ack(tag, ack_o, 1'b1);
    @(negedge clk_i);
    expect_ack(tag, ack_o, 1'b0);
  endtask

  task automatic reset_sequence();
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    expect_ack("during reset", ack_o, 1'b0);
    @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    expect_ack("after reset", ack_o, 1'b0);
  endtask

  task automatic mul_cases();
    md_pkg::operand_t a, b, res;
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        do_op(md_pkg::MD_OP_MUL, 2'b11, corner[i], corner[j],
              mul_ref(corner[i], corner[j]), LAT_MUL, 0, res);
      end
    end
    // mode must not matter for MUL
    repeat (N_RAND) begin
      a = $urandom;
      b = $urandom;
      do_op(md_pkg::MD_OP_MUL, md_pkg::sign_mode_t'($urandom % 4), a, b,
            mul_ref(a, b), LAT_MUL, 0, res);
    end
  endtask

  task automatic mulh_cases();
    md_pkg::operand_t   a, b, res;
    md_pkg::sign_mode_t mode;
    for (int m = 0; m < 3; m++) begin
      // MULH, MULHSU, MULHU
      mode = (m == 0) ? 2'b11 : (m == 1) ? 2'b01 : 2'b00;
      for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 4; j++) begin
          do_op(md_pkg::MD_OP_MULH, mode, corner[i], corner[j],
                mulh_ref(mode, corner[i], corner[j]), LAT_MULH, 0, res);
        end
      end
      repeat (N_RAND) begin
        a = $urandom;
        b = $urandom;
        do_op(md_pkg::MD_OP_MULH, mode, a, b, mulh_ref(mode, a, b), LAT_MULH, 0, res);
      end
    end
  endtask

  task automatic divrem_cases();
    md_pkg::operand_t   a, b, eq, er, res;
    md_pkg::sign_mode_t mode;
    for (int s = 0; s < 2; s++) begin
      mode = (s == 1) ? 2'b11 : 2'b00;
      repeat (N_RAND) begin
        a = $urandom;
        // spread divisor sizes so quotients are not all tiny
        b = $urandom >> ($urandom % XW);
        if ($urandom % 2) b = -b;
        divrem_ref(mode[0], a, b, eq, er);
        do_op(md_pkg::MD_OP_DIV, mode, a, b, eq, div_latency(b), 0, res);
        do_op(md_pkg::MD_OP_REM, mode, a, b, er, div_latency(b), 0, res);
      end
    end
  endtask

  task automatic div_corner_cases();
    md_pkg::operand_t   res;
    md_pkg::sign_mode_t mode;
    for (int s = 0; s < 2; s++) begin
      mode = (s == 1) ? 2'b11 : 2'b00;
      // divide by zero with all-ones and most negative dividends
      for (int i = 2; i < 4; i++) begin
        do_op(md_pkg::MD_OP_DIV, mode, corner[i], '0, '1, LAT_DIV0, 0, res);
        do_op(md_pkg::MD_OP_REM, mode, corner[i], '0, corner[i], LAT_DIV0, 0, res);
      end
    end
    // signed overflow of the most negative value over -1
    do_op(md_pkg::MD_OP_DIV, 2'b11, corner[3], '1, corner[3], LAT_DIV, 0, res);
    do_op(md_pkg::MD_OP_REM, 2'b11, corner[3], '1, '0, LAT_DIV, 0, res);
  endtask

  task automatic handshake_cases();
    md_pkg::operand_t a, b, q, r, res;
    a = $urandom;
    b = $urandom >> ($urandom % XW);
    // req held 10 cycles past ack on both engines
    do_op(md_pkg::MD_OP_MUL, 2'b00, a, b, mul_ref(a, b), LAT_MUL, 10, res);
    divrem_ref(1'b1, a, b, q, r);
    do_op(md_pkg::MD_OP_DIV, 2'b11, a, b, q, div_latency(b), 10, res);
    // engines alternate back to back
    for (int i = 0; i < 8; i++) begin
      a = $urandom;
      b = $urandom >> ($urandom % XW);
      case (i % 4)
        0: do_op(md_pkg::MD_OP_MUL, 2'b11, a, b, mul_ref(a, b), LAT_MUL, 0, res);
        1: begin
          divrem_ref(1'b1, a, b, q, r);
          do_op(md_pkg::MD_OP_DIV, 2'b11, a, b, q, div_latency(b), 0, res);
        end
        2: do_op(md_pkg::MD_OP_MULH, 2'b01, a, b, mulh_ref(2'b01, a, b), LAT_MULH, 0, res);
        default: begin
          divrem_ref(1'b0, a, b, q, r);
          do_op(md_pkg::MD_OP_REM, 2'b00, a, b, r, div_latency(b), 0, res);
        end
      endcase
    end
  endtask

  initial begin
    void'($urandom(32'h83c5_636a));
    rst_ni      = 1'b0;
    req_i       = 1'b0;
    operator_i  = md_pkg::MD_OP_MUL;
    sign_mode_i = '0;
    op_a_i      = '0;
    op_b_i      = '0;
    corner[0]   = '0;
    corner[1]   = md_pkg::operand_t'(1);
    corner[2]   = '1;
    corner[3]   = {1'b1, {(XW-1){1'b0}}};
    reset_sequence();
    mul_cases();
    mulh_cases();
    divrem_cases();
    div_corner_cases();
    handshake_cases();
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+verilog
verilog/md_pkg.sv
verilog/md_engine_if.sv
verilog/md_mult_mac.sv
verilog/md_div_long.sv
verilog/md_unit.sv
verif/md_unit_sva.sv
verif/md_unit_tb.sv

/* Makefile */
# Verilator build and run of the multiply/divide unit testbench

SIM  := obj_dir/Vmd_unit_tb
SRCS := $(shell grep -v '^+' verilog.f) verilog/md_cfg.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): verilog.f $(SRCS)
	verilator --binary --assert -f verilog.f --top-module md_unit_tb

# the log must hold the pass line
run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
